/* flist.f */
rtl/pe_array_pkg.sv
rtl/pe_links.sv
rtl/pe_cell.sv
rtl/pe_column.sv
rtl/reduce_unit.sv
rtl/result_queue.sv
rtl/pe_array_top.sv
sim/tb_pe_array.sv

/* rtl/pe_array_pkg.sv */
`default_nettype none

package pe_array_pkg;

    // operand, product and sum width, arithmetic wraps
    localparam int DATA_W = 32;

    localparam int MODE_W = 2;

    // every element's results for the column
    localparam logic [MODE_W-1:0] MODE_DIRECT = 2'd0;

    // rows of one column added into slot 0
    localparam logic [MODE_W-1:0] MODE_COLUMN = 2'd1;

    // per-row sums over a column sweep
    localparam logic [MODE_W-1:0] MODE_ROW = 2'd2;

    // whole array summed into slot 0 at the end of a sweep
    localparam logic [MODE_W-1:0] MODE_TOTAL = 2'd3;

endpackage

`default_nettype wire

/* rtl/pe_array_top.sv */
`default_nettype none
`timescale 1ns/100ps

module pe_array_top #(
    parameter int ROWS        = 4,
    parameter int COLS        = 8,
    parameter int LANES       = 4,
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2,
    localparam int COL_W      = (COLS > 1) ? $clog2(COLS) : 1
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            in_valid,
    input  logic [COL_W-1:0]                                in_col,
    input  logic [pe_array_pkg::MODE_W-1:0]                 in_mode,
    input  logic [ROWS*LANES-1:0][pe_array_pkg::DATA_W-1:0] in_data,
    input  logic [ROWS*LANES-1:0][pe_array_pkg::DATA_W-1:0] in_par,
    output logic                                            in_credit,
    input  logic                                            clear,
    output logic                                            out_valid,
    output logic [COL_W-1:0]                                out_col,
    output logic [pe_array_pkg::MODE_W-1:0]                 out_mode,
    output logic [ROWS-1:0][pe_array_pkg::DATA_W-1:0]       out_scalar,
    output logic [ROWS*LANES-1:0][pe_array_pkg::DATA_W-1:0] out_vector,
    input  logic                                            out_credit
);

    pe_beat_if #(.ROWS(ROWS), .LANES(LANES), .COL_W(COL_W)) beat_link ();
    pe_result_if #(.ROWS(ROWS), .LANES(LANES), .COL_W(COL_W)) result_link ();

    pe_column #(
        .ROWS(ROWS),
        .LANES(LANES),
        .COL_W(COL_W)
    ) u_column (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_col(in_col),
        .in_mode(in_mode),
        .in_data(in_data),
        .in_par(in_par),
        .beat(beat_link.source)
    );

    reduce_unit #(
        .ROWS(ROWS),
        .COLS(COLS),
        .LANES(LANES)
    ) u_reduce (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .beat(beat_link.sink),
        .result(result_link.source)
    );

    result_queue #(
        .ROWS(ROWS),
        .LANES(LANES),
        .COL_W(COL_W),
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) u_queue (
        .clk(clk),
        .rst(rst),
        .result(result_link.sink),
        .in_credit(in_credit),
        .out_credit(out_credit),
        .out_valid(out_valid),
        .out_col(out_col),
        .out_mode(out_mode),
        .out_scalar(out_scalar),
        .out_vector(out_vector)
    );

endmodule

`default_nettype wire

/* rtl/pe_cell.sv */
`default_nettype none
`timescale 1ns/100ps

module pe_cell #(
    parameter int LANES = 4
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       en,
    input  logic [LANES-1:0][pe_array_pkg::DATA_W-1:0] data,
    input  logic [LANES-1:0][pe_array_pkg::DATA_W-1:0] par,
    output logic [LANES-1:0][pe_array_pkg::DATA_W-1:0] vector,
    output logic [pe_array_pkg::DATA_W-1:0]            scalar
);
    import pe_array_pkg::*;

    logic [LANES-1:0][DATA_W-1:0] prod;
    logic [DATA_W-1:0]            dot;

    // lane products and their wrapped sum
    always_comb begin
        dot = '0;
        for (int l = 0; l < LANES; l++) begin
            prod[l] = data[l] * par[l];
            dot = dot + prod[l];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vector <= '0;
            scalar <= '0;
        end else if (en) begin
            vector <= prod;
            scalar <= dot;
        end
    end

endmodule

`default_nettype wire

/* rtl/pe_column.sv */
`default_nettype none
`timescale 1ns/100ps

module pe_column #(
    parameter int ROWS  = 4,
    parameter int LANES = 4,
    parameter int COL_W = 3
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            in_valid,
    input  logic [COL_W-1:0]                                in_col,
    input  logic [pe_array_pkg::MODE_W-1:0]                 in_mode,
    input  logic [ROWS*LANES-1:0][pe_array_pkg::DATA_W-1:0] in_data,
    input  logic [ROWS*LANES-1:0][pe_array_pkg::DATA_W-1:0] in_par,
    pe_beat_if.source                                       beat
);
    import pe_array_pkg::*;

    logic [ROWS-1:0][DATA_W-1:0]       cell_scalar;
    logic [ROWS*LANES-1:0][DATA_W-1:0] cell_vector;

    // element r takes words r*LANES .. r*LANES+LANES-1
    for (genvar r = 0; r < ROWS; r++) begin : g_row
        pe_cell #(
            .LANES(LANES)
        ) u_cell (
            .clk(clk),
            .rst(rst),
            .en(in_valid),
            .data(in_data[r*LANES +: LANES]),
            .par(in_par[r*LANES +: LANES]),
            .vector(cell_vector[r*LANES +: LANES]),
            .scalar(cell_scalar[r])
        );
    end

    assign beat.scalar = cell_scalar;
    assign beat.vector = cell_vector;

    // tags take the same one cycle as the cell registers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beat.valid <= 1'b0;
        end else begin
            beat.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            beat.col  <= in_col;
            beat.mode <= in_mode;
        end
    end

endmodule

`default_nettype wire

/* rtl/pe_links.sv */
`default_nettype none
`timescale 1ns/100ps

interface pe_beat_if #(
    parameter int ROWS  = 4,
    parameter int LANES = 4,
    parameter int COL_W = 3
);
    import pe_array_pkg::*;

    logic                              valid;
    logic [COL_W-1:0]                  col;
    logic [MODE_W-1:0]                 mode;
    logic [ROWS-1:0][DATA_W-1:0]       scalar;
    logic [ROWS*LANES-1:0][DATA_W-1:0] vector;

    modport source (output valid, col, mode, scalar, vector);
    modport sink (input valid, col, mode, scalar, vector);
endinterface

interface pe_result_if #(
    parameter int ROWS  = 4,
    parameter int LANES = 4,
    parameter int COL_W = 3
);
    import pe_array_pkg::*;

    logic                              push;
    // beat absorbed into the accumulators, its slot goes back
    logic                              release_slot;
    logic [COL_W-1:0]                  col;
    logic [MODE_W-1:0]                 mode;
    logic [ROWS-1:0][DATA_W-1:0]       scalar;
    logic [ROWS*LANES-1:0][DATA_W-1:0] vector;

    modport source (output push, release_slot, col, mode, scalar, vector);
    modport sink (input push, release_slot, col, mode, scalar, vector);
endinterface

`default_nettype wire

/* rtl/reduce_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module reduce_unit #(
    parameter int ROWS  = 4,
    parameter int COLS  = 8,
    parameter int LANES = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    pe_beat_if.sink     beat,
    pe_result_if.source result
);
    import pe_array_pkg::*;

    logic [ROWS-1:0][DATA_W-1:0]       acc_scalar;
    logic [ROWS*LANES-1:0][DATA_W-1:0] acc_vector;
    logic [ROWS-1:0][DATA_W-1:0]       next_scalar;
    logic [ROWS*LANES-1:0][DATA_W-1:0] next_vector;
    logic [DATA_W-1:0]                 col_scalar;
    logic [DATA_W-1:0]                 tot_scalar;
    logic [LANES-1:0][DATA_W-1:0]      col_vector;
    logic [LANES-1:0][DATA_W-1:0]      tot_vector;
    logic [ROWS-1:0][DATA_W-1:0]       emit_scalar;
    logic [ROWS*LANES-1:0][DATA_W-1:0] emit_vector;
    logic                              accumulate;
    logic                              last_col;

    assign accumulate = (beat.mode == MODE_ROW) || (beat.mode == MODE_TOTAL);
    assign last_col   = (int'(beat.col) == COLS - 1);

    // column sums, and running row sums with this beat folded in
    always_comb begin
        col_scalar = '0;
        tot_scalar = '0;
        col_vector = '0;
        tot_vector = '0;
        for (int r = 0; r < ROWS; r++) begin
            next_scalar[r] = acc_scalar[r] + beat.scalar[r];
            col_scalar = col_scalar + beat.scalar[r];
            tot_scalar = tot_scalar + next_scalar[r];
            for (int l = 0; l < LANES; l++) begin
                next_vector[r*LANES+l] = acc_vector[r*LANES+l] + beat.vector[r*LANES+l];
                col_vector[l] = col_vector[l] + beat.vector[r*LANES+l];
                tot_vector[l] = tot_vector[l] + next_vector[r*LANES+l];
            end
        end
    end

    // summed modes land in slot 0, other slots stay zero
    always_comb begin
        emit_scalar = '0;
        emit_vector = '0;
        case (beat.mode)
            MODE_COLUMN: begin
                emit_scalar[0]         = col_scalar;
                emit_vector[LANES-1:0] = col_vector;
            end
            MODE_ROW: begin
                emit_scalar = next_scalar;
                emit_vector = next_vector;
            end
            MODE_TOTAL: begin
                emit_scalar[0]         = tot_scalar;
                emit_vector[LANES-1:0] = tot_vector;
            end
            default: begin
                emit_scalar = beat.scalar;
                emit_vector = beat.vector;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            result.push         <= 1'b0;
            result.release_slot <= 1'b0;
            acc_scalar          <= '0;
            acc_vector          <= '0;
        end else begin
            result.push         <= beat.valid && (!accumulate || last_col);
            result.release_slot <= beat.valid && accumulate && !last_col;
            if (clear) begin
                acc_scalar <= '0;
                acc_vector <= '0;
            end else if (beat.valid && accumulate) begin
                // sweep done, start the next one from zero
                if (last_col) begin
                    acc_scalar <= '0;
                    acc_vector <= '0;
                end else begin
                    acc_scalar <= next_scalar;
                    acc_vector <= next_vector;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            result.col    <= beat.col;
            result.mode   <= beat.mode;
            result.scalar <= emit_scalar;
            result.vector <= emit_vector;
        end
    end

    // column tag from upstream stays inside the array
    a_col_range: assert property (@(posedge clk) disable iff (!rst)
        beat.valid |-> int'(beat.col) < COLS);

endmodule

`default_nettype wire

/* rtl/result_queue.sv */
`default_nettype none
`timescale 1ns/100ps

module result_queue #(
    parameter int ROWS        = 4,
    parameter int LANES       = 4,
    parameter int COL_W       = 3,
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                                            clk,
    input  logic                                            rst,
    pe_result_if.sink                                       result,
    output logic                                            in_credit,
    input  logic                                            out_credit,
    output logic                                            out_valid,
    output logic [COL_W-1:0]                                out_col,
    output logic [pe_array_pkg::MODE_W-1:0]                 out_mode,
    output logic [ROWS-1:0][pe_array_pkg::DATA_W-1:0]       out_scalar,
    output logic [ROWS*LANES-1:0][pe_array_pkg::DATA_W-1:0] out_vector
);
    import pe_array_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    logic [COL_W-1:0]                  mem_col    [QUEUE_DEPTH];
    logic [MODE_W-1:0]                 mem_mode   [QUEUE_DEPTH];
    logic [ROWS-1:0][DATA_W-1:0]       mem_scalar [QUEUE_DEPTH];
    logic [ROWS*LANES-1:0][DATA_W-1:0] mem_vector [QUEUE_DEPTH];
    logic [PTR_W-1:0]                  wr_ptr;
    logic [PTR_W-1:0]                  rd_ptr;
    logic [CNT_W-1:0]                  count;
    logic [CRD_W-1:0]                  credits;
    logic                              pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (int'(ptr) == QUEUE_DEPTH - 1) ? '0 : ptr + 1'b1;
    endfunction

    // a release takes the in_credit slot, so the pop waits one cycle
    assign pop = (count != '0) && (credits != '0) && !result.release_slot;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= CRD_W'(OUT_CREDITS);
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            if (result.push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count     <= count + CNT_W'(result.push) - CNT_W'(pop);
            credits   <= credits - CRD_W'(pop) + CRD_W'(out_credit);
            out_valid <= pop;
            in_credit <= pop || result.release_slot;
        end
    end

    always_ff @(posedge clk) begin
        if (result.push) begin
            mem_col[wr_ptr]    <= result.col;
            mem_mode[wr_ptr]   <= result.mode;
            mem_scalar[wr_ptr] <= result.scalar;
            mem_vector[wr_ptr] <= result.vector;
        end
        if (pop) begin
            out_col    <= mem_col[rd_ptr];
            out_mode   <= mem_mode[rd_ptr];
            out_scalar <= mem_scalar[rd_ptr];
            out_vector <= mem_vector[rd_ptr];
        end
    end

    // upstream credits bound the entries in flight plus stored
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        result.push |-> count < CNT_W'(QUEUE_DEPTH));

    // consumer returns no more than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst)
        credits <= CRD_W'(OUT_CREDITS));

    a_valid_credit: assert property (@(posedge clk) disable iff (!rst)
        out_valid |-> $past(credits) != '0);

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the pe array testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_pe_array -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_pe_array)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

/* sim/tb_pe_array.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_pe_array;
    import pe_array_pkg::*;

    localparam int ROWS        = 4;
    localparam int COLS        = 8;
    localparam int LANES       = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int COL_W       = 3;
    localparam int NW          = ROWS * LANES;
    localparam int EXP_DEPTH   = 64;
    localparam int TIMEOUT     = 500;

    logic                        clk;
    logic                        rst;
    logic                        in_valid;
    logic [COL_W-1:0]            in_col;
    logic [MODE_W-1:0]           in_mode;
    logic [NW-1:0][DATA_W-1:0]   in_data;
    logic [NW-1:0][DATA_W-1:0]   in_par;
    logic                        in_credit;
    logic                        clear;
    logic                        out_valid;
    logic [COL_W-1:0]            out_col;
    logic [MODE_W-1:0]           out_mode;
    logic [ROWS-1:0][DATA_W-1:0] out_scalar;
    logic [NW-1:0][DATA_W-1:0]   out_vector;
    logic                        out_credit;

    // expectation queue filled by stimulus and read by the tracker
    logic [COL_W-1:0]            exp_col    [EXP_DEPTH];
    logic [MODE_W-1:0]           exp_mode   [EXP_DEPTH];
    logic [ROWS-1:0][DATA_W-1:0] exp_scalar [EXP_DEPTH];
    logic [NW-1:0][DATA_W-1:0]   exp_vector [EXP_DEPTH];
    int                          wr_idx;
    int                          rd_idx;
    logic                        head_valid;
    logic [COL_W-1:0]            head_col;
    logic [MODE_W-1:0]           head_mode;
    logic [ROWS-1:0][DATA_W-1:0] head_scalar;
    logic [NW-1:0][DATA_W-1:0]   head_vector;

    // reference model row accumulators
    logic [ROWS-1:0][DATA_W-1:0] acc_scalar;
    logic [NW-1:0][DATA_W-1:0]   acc_vector;

    logic [31:0] lcg_state;
    int          up_credits;
    int          cycle;
    int          hold_until;
    int          owed;
    int          held_pulses;
    int          mismatches = 0;
    int          stray_errs = 0;
    int          credit_errs;
    int          hold_errs;
    int          flow_errs;

    pe_array_top UUT (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_col(in_col),
        .in_mode(in_mode),
        .in_data(in_data),
        .in_par(in_par),
        .in_credit(in_credit),
        .clear(clear),
        .out_valid(out_valid),
        .out_col(out_col),
        .out_mode(out_mode),
        .out_scalar(out_scalar),
        .out_vector(out_vector),
        .out_credit(out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upstream credits, cycle count and the queue head
    initial begin
        up_credits  = QUEUE_DEPTH;
        cycle       = 0;
        rd_idx      = 0;
        credit_errs = 0;
        head_valid  = 1'b0;
        forever begin
            @(posedge clk);
            cycle++;
            if (rst) begin
                up_credits = up_credits - int'(in_valid) + int'(in_credit);
                assert (up_credits <= QUEUE_DEPTH) else begin
                    credit_errs++;
                    $display("DUT returned more input credits than upstream had used");
                end
                if (out_valid && rd_idx < wr_idx) begin
                    rd_idx++;
                end
            end
            head_valid  = rd_idx < wr_idx;
            head_col    = exp_col[rd_idx];
            head_mode   = exp_mode[rd_idx];
            head_scalar = exp_scalar[rd_idx];
            head_vector = exp_vector[rd_idx];
        end
    end

    // consumer returns each credit at once unless holding off
    initial begin
        out_credit  = 1'b0;
        owed        = 0;
        held_pulses = 0;
        hold_errs   = 0;
        forever begin
            @(negedge clk);
            if (out_valid) begin
                owed++;
            end
            if (cycle < hold_until) begin
                if (out_valid) begin
                    held_pulses++;
                end
                assert (held_pulses <= OUT_CREDITS) else begin
                    hold_errs++;
                    $display("more results sent than credits while the consumer held off");
                end
                out_credit = 1'b0;
            end else begin
                held_pulses = 0;
                out_credit  = owed > 0;
                if (owed > 0) begin
                    owed--;
                end
            end
        end
    end

    a_expected: assert property (@(negedge clk) disable iff (!rst) out_valid |-> head_valid)
        else begin
            stray_errs++;
            $display("out_valid seen with no expected result pending");
        end

    a_col: assert property (@(negedge clk) disable iff (!rst)
        (out_valid && head_valid) |-> out_col == head_col)
        else begin
            mismatches++;
            $display("Mismatch out_col: got %h expected %h", out_col, head_col);
        end

    a_mode: assert property (@(negedge clk) disable iff (!rst)
        (out_valid && head_valid) |-> out_mode == head_mode)
        else begin
            mismatches++;
            $display("Mismatch out_mode: got %h expected %h", out_mode, head_mode);
        end

    a_scalar: assert property (@(negedge clk) disable iff (!rst)
        (out_valid && head_valid) |-> out_scalar == head_scalar)
        else begin
            mismatches++;
            $display("Mismatch out_scalar: got %h expected %h", out_scalar, head_scalar);
        end

    a_vector: assert property (@(negedge clk) disable iff (!rst)
        (out_valid && head_valid) |-> out_vector == head_vector)
        else begin
            mismatches++;
            $display("Mismatch out_vector: got %h expected %h", out_vector, head_vector);
        end

    task automatic push_expected(input int col, input logic [MODE_W-1:0] mode,
                                 input logic [ROWS-1:0][DATA_W-1:0] es,
                                 input logic [NW-1:0][DATA_W-1:0] ev);
        if (wr_idx < EXP_DEPTH) begin
            exp_col[wr_idx]    = COL_W'(col);
            exp_mode[wr_idx]   = mode;
            exp_scalar[wr_idx] = es;
            exp_vector[wr_idx] = ev;
            wr_idx++;
        end
    endtask

    // one beat with random operands, and its expected result if any
    task automatic send_beat(input int col, input logic [MODE_W-1:0] mode);
        logic [NW-1:0][DATA_W-1:0]   prod;
        logic [ROWS-1:0][DATA_W-1:0] dot;
        logic [ROWS-1:0][DATA_W-1:0] es;
        logic [NW-1:0][DATA_W-1:0]   ev;
        int                          n;
        n = 0;
        while (up_credits == 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (up_credits == 0) begin
            flow_errs++;
            $display("timed out waiting for an upstream credit");
            return;
        end
        es = '0;
        ev = '0;
        for (int r = 0; r < ROWS; r++) begin
            dot[r] = '0;
            for (int l = 0; l < LANES; l++) begin
                in_data[r*LANES+l] = lcg_next();
                in_par[r*LANES+l]  = lcg_next();
                prod[r*LANES+l]    = in_data[r*LANES+l] * in_par[r*LANES+l];
                dot[r]             = dot[r] + prod[r*LANES+l];
            end
        end
        if (mode == MODE_DIRECT) begin
            push_expected(col, mode, dot, prod);
        end else if (mode == MODE_COLUMN) begin
            for (int r = 0; r < ROWS; r++) begin
                es[0] = es[0] + dot[r];
                for (int l = 0; l < LANES; l++) begin
                    ev[l] = ev[l] + prod[r*LANES+l];
                end
            end
            push_expected(col, mode, es, ev);
        end else begin
            for (int r = 0; r < ROWS; r++) begin
                acc_scalar[r] = acc_scalar[r] + dot[r];
                for (int l = 0; l < LANES; l++) begin
                    acc_vector[r*LANES+l] = acc_vector[r*LANES+l] + prod[r*LANES+l];
                end
            end
            if (col == COLS - 1) begin
                if (mode == MODE_ROW) begin
                    es = acc_scalar;
                    ev = acc_vector;
                end else begin
                    for (int r = 0; r < ROWS; r++) begin
                        es[0] = es[0] + acc_scalar[r];
                        for (int l = 0; l < LANES; l++) begin
                            ev[l] = ev[l] + acc_vector[r*LANES+l];
                        end
                    end
                end
                push_expected(col, mode, es, ev);
                acc_scalar = '0;
                acc_vector = '0;
            end
        end
        in_col   = COL_W'(col);
        in_mode  = mode;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic sweep(input logic [MODE_W-1:0] mode);
        for (int c = 0; c < COLS; c++) begin
            send_beat(c, mode);
        end
    endtask

    // all results out and all upstream credits back
    task automatic wait_drain();
        int n;
        n = 0;
        while ((rd_idx != wr_idx || up_credits != QUEUE_DEPTH) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rd_idx != wr_idx || up_credits != QUEUE_DEPTH) begin
            flow_errs++;
            $display("timed out waiting for %0d pending results to drain", wr_idx - rd_idx);
        end
    endtask

    initial begin
        rst        = 1'b0;
        in_valid   = 1'b0;
        in_col     = '0;
        in_mode    = MODE_DIRECT;
        in_data    = '0;
        in_par     = '0;
        clear      = 1'b0;
        lcg_state  = 32'h8bef;
        acc_scalar = '0;
        acc_vector = '0;
        wr_idx     = 0;
        hold_until = 0;
        flow_errs  = 0;
        repeat (16) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        sweep(MODE_DIRECT);
        wait_drain();
        sweep(MODE_COLUMN);
        wait_drain();
        sweep(MODE_ROW);
        sweep(MODE_ROW);
        wait_drain();
        sweep(MODE_TOTAL);
        wait_drain();
        // consumer holds its credits while a full sweep arrives
        hold_until = cycle + 40;
        sweep(MODE_DIRECT);
        wait_drain();
        for (int c = 0; c < COLS / 2; c++) begin
            send_beat(c, MODE_ROW);
        end
        wait_drain();
        clear      = 1'b1;
        acc_scalar = '0;
        acc_vector = '0;
        @(negedge clk);
        clear = 1'b0;
        sweep(MODE_ROW);
        wait_drain();
        $display("errors: %0d mismatches, %0d other failures", mismatches,
                 stray_errs + credit_errs + hold_errs + flow_errs);
        if (mismatches == 0 && stray_errs + credit_errs + hold_errs + flow_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
